// ==== hdl/uart_hub_macros.svh ====
`ifndef UART_HUB_MACROS_SVH
`define UART_HUB_MACROS_SVH

// Buffer depths in entries
`define UART_RX_DEPTH 8
`define UART_TX_DEPTH 4

// Serial receive lanes sharing the receive buffer
`define UART_LANES 2

// Bit period counter width in clock cycles
`define UART_SPB_W 24

// Widest frame: start, 8 data, parity, 2 stop
`define UART_FRAME_W 12

// Credit counters
`define UART_CREDIT_W 8

`endif

// ==== hdl/uart_pkg.sv ====
`include "uart_hub_macros.svh"

package uart_pkg;

    // Data bits per frame
    typedef enum logic {
        DATA_SEVEN,
        DATA_EIGHT
    } data_bits_t;

    // Parity bit after the data bits
    typedef enum logic [2:0] {
        PARITY_NONE,
        PARITY_EVEN,
        PARITY_ODD,
        PARITY_MARK,
        PARITY_SPACE
    } parity_t;

    typedef enum logic {
        STOP_ONE,
        STOP_TWO
    } stop_bits_t;

    // Run-time frame format, bit period counted in clock cycles
    typedef struct packed {
        data_bits_t             data_bits;
        parity_t                parity;
        stop_bits_t             stop_bits;
        logic [`UART_SPB_W-1:0] samples_per_bit;
    } uart_config_t;

    // Receive buffer entry, tagged with its lane
    typedef struct packed {
        logic       lane;
        logic [7:0] data;
    } host_word_t;

    // Transmit buffer entry
    typedef logic [7:0] uart_byte_t;

endpackage

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ns
`include "uart_hub_macros.svh"

module uart_rx (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   rxd_i,
    input  uart_pkg::uart_config_t cfg_i,
    output logic [7:0]             data_o,
    output logic                   data_valid_o
);
    import uart_pkg::*;

    logic [2:0]                sync_r;
    logic [`UART_SPB_W-1:0]    center_cnt_r;
    logic                      sample_en;
    logic [`UART_FRAME_W-1:0]  frame_r;
    logic [`UART_FRAME_W-1:0]  frame_next;
    logic [`UART_FRAME_W-1:0]  frame_view;
    logic [3:0]                frame_len;
    logic                      start_good;
    logic                      parity_bit;
    logic                      data_xor;
    logic                      parity_good;
    logic [1:0]                stop_bits;
    logic                      stop_good;
    logic                      frame_good;
    logic [7:0]                data_r;
    logic                      data_valid_r;

    // Input synchroniser, oldest sample in bit 0
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sync_r <= 3'b111;
        end else begin
            sync_r <= {rxd_i, sync_r[2:1]};
        end
    end

    // Every line edge restarts a half-bit countdown to the bit centre
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            center_cnt_r <= '0;
        end else if (sync_r[0] != sync_r[1]) begin
            center_cnt_r <= {1'b0, cfg_i.samples_per_bit[`UART_SPB_W-1:1]};
        end else if (sample_en) begin
            center_cnt_r <= cfg_i.samples_per_bit - 1'b1;
        end else begin
            center_cnt_r <= center_cnt_r - 1'b1;
        end
    end

    assign sample_en = (center_cnt_r == '0);

    // Newest sample enters at the top
    assign frame_next = {sync_r[0], frame_r[`UART_FRAME_W-1:1]};

    always_comb begin
        frame_len = (cfg_i.data_bits == DATA_SEVEN) ? 4'd9 : 4'd10;
        if (cfg_i.parity != PARITY_NONE) begin
            frame_len = frame_len + 4'd1;
        end
        if (cfg_i.stop_bits == STOP_TWO) begin
            frame_len = frame_len + 4'd1;
        end

        // Align the configured frame so the start bit sits in bit 0
        frame_view = frame_next >> (4'd12 - frame_len);
        start_good = !frame_view[0];

        data_xor = ^frame_view[7:1];
        if (cfg_i.data_bits == DATA_EIGHT) begin
            data_xor = data_xor ^ frame_view[8];
        end
        parity_bit = (cfg_i.data_bits == DATA_SEVEN) ? frame_view[8] : frame_view[9];

        case (cfg_i.parity)
            PARITY_NONE:  parity_good = 1'b1;
            PARITY_EVEN:  parity_good = (parity_bit == data_xor);
            PARITY_ODD:   parity_good = (parity_bit != data_xor);
            PARITY_MARK:  parity_good = parity_bit;
            PARITY_SPACE: parity_good = !parity_bit;
            default:      parity_good = 1'b0;
        endcase

        if (cfg_i.data_bits == DATA_SEVEN) begin
            stop_bits = (cfg_i.parity == PARITY_NONE) ? frame_view[9:8] : frame_view[10:9];
        end else begin
            stop_bits = (cfg_i.parity == PARITY_NONE) ? frame_view[10:9] : frame_view[11:10];
        end
        stop_good = (cfg_i.stop_bits == STOP_ONE) ? stop_bits[0] : (&stop_bits);

        frame_good = sample_en && start_good && parity_good && stop_good;
    end

    // Shift register, cleared to idle after each good frame
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            frame_r <= '1;
        end else if (frame_good) begin
            frame_r <= '1;
        end else if (sample_en) begin
            frame_r <= frame_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_valid_r <= 1'b0;
        end else begin
            data_valid_r <= frame_good;
        end
    end

    // Seven-bit frames deliver bit 7 as zero
    always_ff @(posedge clk_i) begin
        if (frame_good) begin
            data_r <= {(cfg_i.data_bits == DATA_EIGHT) && frame_view[8], frame_view[7:1]};
        end
    end

    assign data_o       = data_r;
    assign data_valid_o = data_valid_r;

    // One pulse per frame, never back to back
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_valid_r |=> !data_valid_r);

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ns
`include "uart_hub_macros.svh"

module uart_tx (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  uart_pkg::uart_config_t cfg_i,
    input  logic                   valid_i,
    input  logic [7:0]             data_i,
    output logic                   credit_o,
    output logic                   txd_o
);
    import uart_pkg::*;

    logic                   busy_r;
    logic                   init_r;
    logic                   credit_r;
    logic                   txd_r;
    logic [10:0]            shift_r;
    logic [3:0]             bits_left_r;
    logic [`UART_SPB_W-1:0] bit_cnt_r;
    logic [10:0]            body;
    logic [3:0]             body_len;
    logic                   data_xor;
    logic                   parity_bit;
    logic                   accept;
    logic                   frame_done;

    // Frame body after the start bit, LSB first
    always_comb begin
        data_xor = ^data_i[6:0];
        if (cfg_i.data_bits == DATA_EIGHT) begin
            data_xor = data_xor ^ data_i[7];
        end

        case (cfg_i.parity)
            PARITY_EVEN: parity_bit = data_xor;
            PARITY_ODD:  parity_bit = !data_xor;
            PARITY_MARK: parity_bit = 1'b1;
            default:     parity_bit = 1'b0;
        endcase

        // Ones above the data serve as stop bits
        body = '1;
        if (cfg_i.data_bits == DATA_SEVEN) begin
            body[6:0] = data_i[6:0];
            if (cfg_i.parity != PARITY_NONE) begin
                body[7] = parity_bit;
            end
            body_len = 4'd8;
        end else begin
            body[7:0] = data_i;
            if (cfg_i.parity != PARITY_NONE) begin
                body[8] = parity_bit;
            end
            body_len = 4'd9;
        end
        if (cfg_i.parity != PARITY_NONE) begin
            body_len = body_len + 4'd1;
        end
        if (cfg_i.stop_bits == STOP_TWO) begin
            body_len = body_len + 4'd1;
        end
    end

    assign accept     = valid_i && !busy_r;
    assign frame_done = busy_r && (bit_cnt_r == '0) && (bits_left_r == '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_r      <= 1'b0;
            txd_r       <= 1'b1;
            bits_left_r <= '0;
            bit_cnt_r   <= '0;
        end else if (accept) begin
            // Start bit goes out on the next cycle
            busy_r      <= 1'b1;
            txd_r       <= 1'b0;
            bits_left_r <= body_len;
            bit_cnt_r   <= cfg_i.samples_per_bit - 1'b1;
        end else if (busy_r) begin
            if (bit_cnt_r != '0) begin
                bit_cnt_r <= bit_cnt_r - 1'b1;
            end else if (bits_left_r != '0) begin
                txd_r       <= shift_r[0];
                bits_left_r <= bits_left_r - 1'b1;
                bit_cnt_r   <= cfg_i.samples_per_bit - 1'b1;
            end else begin
                busy_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            shift_r <= body;
        end else if (busy_r && (bit_cnt_r == '0)) begin
            shift_r <= {1'b1, shift_r[10:1]};
        end
    end

    // Single credit, handed out once after reset and after every frame
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            init_r   <= 1'b1;
            credit_r <= 1'b0;
        end else begin
            init_r   <= 1'b0;
            credit_r <= init_r || frame_done;
        end
    end

    assign credit_o = credit_r;
    assign txd_o    = txd_r;

    // The buffer only sends with the credit it was given
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i |-> !busy_r);

endmodule

// ==== hdl/credit_fifo.sv ====
`timescale 1ns/1ns
`include "uart_hub_macros.svh"

module credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     in_credit_o,
    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     out_credit_i
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t                  mem_r [DEPTH];
    logic [PTR_W-1:0]          wr_ptr_r;
    logic [PTR_W-1:0]          rd_ptr_r;
    logic [CNT_W-1:0]          count_r;
    logic [`UART_CREDIT_W-1:0] out_cred_r;
    logic                      credit_r;
    logic                      pop;

    // Pop whenever data and downstream credit are both present
    assign pop         = (count_r != '0) && (out_cred_r != '0);
    assign out_valid_o = pop;
    assign out_data_o  = mem_r[rd_ptr_r];
    assign in_credit_o = credit_r;

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            mem_r[wr_ptr_r] <= in_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_r   <= '0;
            rd_ptr_r   <= '0;
            count_r    <= '0;
            out_cred_r <= '0;
            credit_r   <= 1'b0;
        end else begin
            // Pointers wrap at DEPTH, which need not be a power of two
            if (in_valid_i) begin
                wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
            end
            if (pop) begin
                rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
            end

            case ({in_valid_i, pop})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase

            case ({out_credit_i, pop})
                2'b10:   out_cred_r <= out_cred_r + 1'b1;
                2'b01:   out_cred_r <= out_cred_r - 1'b1;
                default: out_cred_r <= out_cred_r;
            endcase

            // Freed slot goes back to the sender
            credit_r <= pop;
        end
    end

    // Sender's credit count must keep it from overfilling the buffer
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_valid_i |-> (count_r < CNT_W'(DEPTH)));

endmodule

// ==== hdl/lane_arbiter.sv ====
`timescale 1ns/1ns
`include "uart_hub_macros.svh"

module lane_arbiter (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic [`UART_LANES-1:0][7:0]  lane_data_i,
    input  logic [`UART_LANES-1:0]       lane_valid_i,
    output logic                         push_o,
    output uart_pkg::host_word_t         word_o,
    input  logic                         credit_i
);
    logic [`UART_LANES-1:0]    slot_full_r;
    logic [7:0]                slot_data_r [`UART_LANES];
    logic [`UART_CREDIT_W-1:0] credit_r;
    logic                      last_r;
    logic                      grant_lane;
    logic                      grant;
    logic [`UART_LANES-1:0]    take;
    logic [`UART_LANES-1:0]    capture;

    always_comb begin
        // Both full: alternate away from the last winner
        if (&slot_full_r) begin
            grant_lane = !last_r;
        end else begin
            grant_lane = slot_full_r[1];
        end
        grant = (|slot_full_r) && (credit_r != '0);

        take = '0;
        if (grant) begin
            take[grant_lane] = 1'b1;
        end

        // New byte lands only in an empty or draining slot
        capture = lane_valid_i & (~slot_full_r | take);
    end

    assign push_o      = grant;
    assign word_o.lane = grant_lane;
    assign word_o.data = slot_data_r[grant_lane];

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `UART_LANES; i++) begin
            if (capture[i]) begin
                slot_data_r[i] <= lane_data_i[i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            slot_full_r <= '0;
            last_r      <= 1'b0;
            credit_r    <= `UART_CREDIT_W'(`UART_RX_DEPTH);
        end else begin
            slot_full_r <= capture | (slot_full_r & ~take);
            if (grant) begin
                last_r <= grant_lane;
            end
            case ({credit_i, grant})
                2'b10:   credit_r <= credit_r + 1'b1;
                2'b01:   credit_r <= credit_r - 1'b1;
                default: credit_r <= credit_r;
            endcase
        end
    end

    // Buffer returns no more credits than it has slots
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_r <= `UART_CREDIT_W'(`UART_RX_DEPTH));

endmodule

// ==== hdl/uart_hub.sv ====
`timescale 1ns/1ns
`include "uart_hub_macros.svh"

module uart_hub (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  uart_pkg::data_bits_t   cfg_data_bits_i,
    input  uart_pkg::parity_t      cfg_parity_i,
    input  uart_pkg::stop_bits_t   cfg_stop_bits_i,
    input  logic [`UART_SPB_W-1:0] cfg_samples_per_bit_i,
    input  logic [`UART_LANES-1:0] rxd_i,
    output logic                   host_valid_o,
    output logic                   host_lane_o,
    output logic [7:0]             host_data_o,
    input  logic                   host_credit_i,
    input  logic                   tx_valid_i,
    input  logic [7:0]             tx_data_i,
    output logic                   tx_credit_o,
    output logic                   txd_o
);
    import uart_pkg::*;

    uart_config_t                cfg;
    logic [`UART_LANES-1:0][7:0] lane_data;
    logic [`UART_LANES-1:0]      lane_valid;
    logic                        arb_push;
    host_word_t                  arb_word;
    logic                        arb_credit;
    host_word_t                  host_word;
    logic                        tx_valid;
    uart_byte_t                  tx_byte;
    logic                        tx_credit;

    assign cfg.data_bits       = cfg_data_bits_i;
    assign cfg.parity          = cfg_parity_i;
    assign cfg.stop_bits       = cfg_stop_bits_i;
    assign cfg.samples_per_bit = cfg_samples_per_bit_i;

    assign host_lane_o = host_word.lane;
    assign host_data_o = host_word.data;

    // Receive lanes
    uart_rx rx0 (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .rxd_i        (rxd_i[0]),
        .cfg_i        (cfg),
        .data_o       (lane_data[0]),
        .data_valid_o (lane_valid[0])
    );

    uart_rx rx1 (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .rxd_i        (rxd_i[1]),
        .cfg_i        (cfg),
        .data_o       (lane_data[1]),
        .data_valid_o (lane_valid[1])
    );

    lane_arbiter arb0 (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .lane_data_i  (lane_data),
        .lane_valid_i (lane_valid),
        .push_o       (arb_push),
        .word_o       (arb_word),
        .credit_i     (arb_credit)
    );

    credit_fifo #(
        .payload_t (host_word_t),
        .DEPTH     (`UART_RX_DEPTH)
    ) rx_buf (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (arb_push),
        .in_data_i    (arb_word),
        .in_credit_o  (arb_credit),
        .out_valid_o  (host_valid_o),
        .out_data_o   (host_word),
        .out_credit_i (host_credit_i)
    );

    // Transmit path
    credit_fifo #(
        .payload_t (uart_byte_t),
        .DEPTH     (`UART_TX_DEPTH)
    ) tx_buf (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (tx_valid_i),
        .in_data_i    (tx_data_i),
        .in_credit_o  (tx_credit_o),
        .out_valid_o  (tx_valid),
        .out_data_o   (tx_byte),
        .out_credit_i (tx_credit)
    );

    uart_tx tx0 (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .cfg_i    (cfg),
        .valid_i  (tx_valid),
        .data_i   (tx_byte),
        .credit_o (tx_credit),
        .txd_o    (txd_o)
    );

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Reset lifts on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== verif/tb_uart_hub.sv ====
`timescale 1ns/1ns
`include "uart_hub_macros.svh"

module tb_uart_hub;
    import uart_pkg::*;

    localparam int BIT_CYCLES    = 16;
    localparam int WORD_TIMEOUT  = 30 * BIT_CYCLES;
    localparam int FRAME_TIMEOUT = 30 * BIT_CYCLES;

    logic                   clk;
    logic                   rst_n;
    data_bits_t             cfg_data_bits;
    parity_t                cfg_parity;
    stop_bits_t             cfg_stop_bits;
    logic [`UART_SPB_W-1:0] cfg_spb;
    logic [`UART_LANES-1:0] rxd;
    logic                   host_valid;
    logic                   host_lane;
    logic [7:0]             host_data;
    logic                   host_credit;
    logic                   tx_valid;
    logic [7:0]             tx_data;
    logic                   tx_credit;
    logic                   txd;

    // Words seen at the host port, lane in bit 8
    logic [8:0] word_q [$];
    logic [7:0] tx_bytes [`UART_TX_DEPTH];
    int         host_credits;
    int         tx_credit_count;
    int         seed;

    tb_clock clock0 (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    uart_hub dut0 (
        .clk_i                 (clk),
        .rst_n_i               (rst_n),
        .cfg_data_bits_i       (cfg_data_bits),
        .cfg_parity_i          (cfg_parity),
        .cfg_stop_bits_i       (cfg_stop_bits),
        .cfg_samples_per_bit_i (cfg_spb),
        .rxd_i                 (rxd),
        .host_valid_o          (host_valid),
        .host_lane_o           (host_lane),
        .host_data_o           (host_data),
        .host_credit_i         (host_credit),
        .tx_valid_i            (tx_valid),
        .tx_data_i             (tx_data),
        .tx_credit_o           (tx_credit),
        .txd_o                 (txd)
    );

    // Host side monitor, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && host_valid) begin
            word_q.push_back({host_lane, host_data});
        end
        if (rst_n && tx_credit) begin
            tx_credit_count = tx_credit_count + 1;
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h",
                                     name, actual, expected));
        end
    endtask

    function automatic logic [7:0] random_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic int frame_length();
        int len;
        len = (cfg_data_bits == DATA_EIGHT) ? 10 : 9;
        if (cfg_parity != PARITY_NONE) begin
            len++;
        end
        if (cfg_stop_bits == STOP_TWO) begin
            len++;
        end
        return len;
    endfunction

    // Line levels in send order, start bit in bit 0, stop bits stay high
    function automatic logic [11:0] frame_bits(input logic [7:0] value, input logic flip);
        logic [11:0] bits;
        logic        par;
        int          n;
        bits = '1;
        bits[0] = 1'b0;
        par = 1'b0;
        n = (cfg_data_bits == DATA_EIGHT) ? 8 : 7;
        for (int i = 0; i < n; i++) begin
            bits[1 + i] = value[i];
            par = par ^ value[i];
        end
        case (cfg_parity)
            PARITY_ODD:   par = !par;
            PARITY_MARK:  par = 1'b1;
            PARITY_SPACE: par = 1'b0;
            default:      par = par;
        endcase
        if (cfg_parity != PARITY_NONE) begin
            bits[n + 1] = par ^ flip;
        end
        return bits;
    endfunction

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst_n !== 1'b1) begin
            if (waited == 100) begin
                report_failure("Reset was never released");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic set_format(input data_bits_t bits, input parity_t par,
                              input stop_bits_t stops);
        @(negedge clk);
        cfg_data_bits = bits;
        cfg_parity    = par;
        cfg_stop_bits = stops;
        // Idle line in the new format before any frame
        repeat (2 * BIT_CYCLES) @(negedge clk);
    endtask

    // One frame per selected lane, lanes left out stay idle
    task automatic send_frames(input logic [1:0] lanes, input logic [7:0] byte0,
                               input logic [7:0] byte1, input logic flip);
        logic [11:0] bits0;
        logic [11:0] bits1;
        int          len;
        bits0 = frame_bits(byte0, flip);
        bits1 = frame_bits(byte1, flip);
        len = frame_length();
        for (int i = 0; i < len; i++) begin
            @(negedge clk);
            rxd[0] = lanes[0] ? bits0[i] : 1'b1;
            rxd[1] = lanes[1] ? bits1[i] : 1'b1;
            repeat (BIT_CYCLES - 1) @(negedge clk);
        end
    endtask

    task automatic grant_credit();
        @(negedge clk);
        host_credit = 1'b1;
        @(negedge clk);
        host_credit = 1'b0;
        host_credits++;
    endtask

    task automatic wait_words(input int count);
        int waited;
        waited = 0;
        while (word_q.size() < count) begin
            if (waited == WORD_TIMEOUT) begin
                report_failure("Timed out waiting for a word at the host port");
            end
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic expect_word(input logic lane, input logic [7:0] data);
        logic [8:0] word;
        wait_words(1);
        word = word_q.pop_front();
        host_credits--;
        check("host_lane_o", word[8], lane);
        check("host_data_o", word[7:0], data);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            if (word_q.size() != 0) begin
                report_failure("A word arrived at the host port where none was expected");
            end
        end
    endtask

    task automatic sample_tx(output logic [11:0] bits);
        int waited;
        int len;
        waited = 0;
        bits = '1;
        len = frame_length();
        @(negedge clk);
        while (txd !== 1'b0) begin
            if (waited == FRAME_TIMEOUT) begin
                report_failure("Timed out waiting for a start bit on txd_o");
            end
            @(negedge clk);
            waited++;
        end
        // Middle of the start bit
        repeat (BIT_CYCLES / 2) @(negedge clk);
        for (int i = 0; i < len; i++) begin
            bits[i] = txd;
            if (i != len - 1) begin
                repeat (BIT_CYCLES) @(negedge clk);
            end
        end
    endtask

    task automatic push_tx_bytes();
        for (int i = 0; i < `UART_TX_DEPTH; i++) begin
            @(negedge clk);
            tx_valid = 1'b1;
            tx_data  = tx_bytes[i];
        end
        @(negedge clk);
        tx_valid = 1'b0;
    endtask

    task automatic after_reset_idle();
        repeat (3 * BIT_CYCLES) begin
            @(negedge clk);
            check("host_valid_o", host_valid, 1'b0);
            check("tx_credit_o", tx_credit, 1'b0);
            check("txd_o", txd, 1'b1);
        end
    endtask

    task automatic single_lane_8n1();
        logic [7:0] value;
        value = random_byte();
        set_format(DATA_EIGHT, PARITY_NONE, STOP_ONE);
        grant_credit();
        send_frames(2'b01, value, 8'hff, 1'b0);
        expect_word(1'b0, value);
    endtask

    task automatic seven_bit_parity();
        set_format(DATA_SEVEN, PARITY_EVEN, STOP_TWO);
        grant_credit();
        // Bit 7 never goes on the line
        send_frames(2'b01, 8'hc5, 8'hff, 1'b0);
        expect_word(1'b0, 8'h45);
        grant_credit();
        grant_credit();
        // Receiver checks every bit position, so a low bit followed by an
        // idle line would frame as 0x7f; the good frame right behind the bad
        // one keeps low bits in those stop positions
        send_frames(2'b01, 8'hc5, 8'hff, 1'b1);
        send_frames(2'b01, 8'h12, 8'hff, 1'b0);
        expect_word(1'b0, 8'h12);
        expect_quiet(4 * 12 * BIT_CYCLES);
    endtask

    task automatic both_lanes();
        logic [7:0] value0;
        logic [7:0] value1;
        logic [8:0] first;
        logic [8:0] second;
        value0 = random_byte();
        value1 = random_byte();
        set_format(DATA_EIGHT, PARITY_NONE, STOP_ONE);
        while (host_credits < 2) begin
            grant_credit();
        end
        send_frames(2'b11, value0, value1, 1'b0);
        wait_words(2);
        first = word_q.pop_front();
        second = word_q.pop_front();
        host_credits = host_credits - 2;
        // Either lane may win the first grant
        if (first[8]) begin
            {first, second} = {second, first};
        end
        check("host_lane_o", first[8], 1'b0);
        check("host_data_o", first[7:0], value0);
        check("host_lane_o", second[8], 1'b1);
        check("host_data_o", second[7:0], value1);
        expect_quiet(2 * 10 * BIT_CYCLES);
    endtask

    task automatic back_pressure();
        logic [7:0] values [3];
        for (int i = 0; i < 3; i++) begin
            values[i] = random_byte();
        end
        for (int i = 0; i < 3; i++) begin
            send_frames(2'b01, values[i], 8'hff, 1'b0);
        end
        expect_quiet(4 * BIT_CYCLES);
        // One credit, one word, oldest first
        for (int i = 0; i < 3; i++) begin
            grant_credit();
            expect_word(1'b0, values[i]);
            expect_quiet(2 * BIT_CYCLES);
        end
    endtask

    task automatic transmit_8o1();
        logic [11:0] sampled;
        set_format(DATA_EIGHT, PARITY_ODD, STOP_ONE);
        for (int i = 0; i < `UART_TX_DEPTH; i++) begin
            tx_bytes[i] = random_byte();
        end
        fork
            push_tx_bytes();
            for (int i = 0; i < `UART_TX_DEPTH; i++) begin
                sample_tx(sampled);
                check("txd_o frame", sampled, frame_bits(tx_bytes[i], 1'b0));
            end
        join
        check("tx_credit_o pulses", tx_credit_count, `UART_TX_DEPTH);
    endtask

    initial begin
        seed            = 77442;
        host_credits    = 0;
        tx_credit_count = 0;
        cfg_data_bits   = DATA_EIGHT;
        cfg_parity      = PARITY_NONE;
        cfg_stop_bits   = STOP_ONE;
        cfg_spb         = `UART_SPB_W'(BIT_CYCLES);
        rxd             = '1;
        host_credit     = 1'b0;
        tx_valid        = 1'b0;
        tx_data         = 8'h00;

        wait_reset_release();
        after_reset_idle();
        single_lane_8n1();
        seven_bit_parity();
        both_lanes();
        back_pressure();
        transmit_8o1();

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== uart_hub.f ====
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/credit_fifo.sv
hdl/lane_arbiter.sv
hdl/uart_hub.sv
verif/tb_clock.sv
verif/tb_uart_hub.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f uart_hub.f \
    --top-module tb_uart_hub \
    -o sim_uart_hub

./obj_dir/sim_uart_hub 2>&1 | tee sim.log

if grep -q "Done: no errors" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
